/* verilog.f */
+incdir+hw
hw/sd_proto_pkg.sv
hw/sd_host_pkg.sv
hw/spi_clock_gen.sv
hw/spi_byte_shifter.sv
hw/sd_cmd_framer.sv
hw/sd_hold_reg.sv
hw/sd_reader_ctrl.sv
hw/sd_card_reader.sv
verif/sd_card_model.sv
verif/tb_sd_card_reader.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_sd_card_reader \
    -f verilog.f --Mdir obj_dir -o sim_tb

out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

/* verif/tb_sd_card_reader.sv */
`timescale 1ns/1ps
`include "sd_settings.svh"

module tb_sd_card_reader;
    import sd_host_pkg::*;
    import sd_proto_pkg::*;

    localparam int NUM_RANDOM = 4;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic        req_ready;
    read_req_t   req;
    logic        data_valid;
    logic        data_ready;
    data_byte_t  data;
    logic        cs_n;
    logic        sck;
    logic        mosi;
    logic        miso;
    logic        busy;
    logic        error;
    logic [31:0] fail_sector;

    data_byte_t  exp_q[$];        // Bytes still owed by the DUT
    int          mismatch_count;
    int          other_count;
    int          log_pos;
    logic [31:0] rnd_sector[NUM_RANDOM];
    logic [7:0]  rnd_count[NUM_RANDOM];
    longint      watchdog_ns;
    logic        random_ready;
    logic        prev_stall;
    data_byte_t  prev_data;

    sd_card_reader sd_card_reader_inst (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .data_valid(data_valid), .data_ready(data_ready), .data(data),
        .cs_n(cs_n), .sck(sck), .mosi(mosi), .miso(miso),
        .busy(busy), .error(error)
    );

    sd_card_model card_inst (
        .cs_n(cs_n), .sck(sck), .mosi(mosi), .miso(miso), .fail_sector(fail_sector)
    );

    always #50 clk = ~clk;

    function automatic data_byte_t pattern_byte(input logic [31:0] sector, input int offset);
        return sector[7:0] * 8'd7 + offset[7:0];
    endfunction

    always @(posedge clk) begin
        #1;
        if (random_ready)
            data_ready = ($urandom % 4) != 0;
    end

    always @(negedge clk) begin : data_monitor
        data_byte_t expected;
        if (rst_n) begin
            if (prev_stall) begin
                if (!data_valid) begin
                    other_count++;
                    $display("data_valid dropped while a byte was waiting");
                end else if (data !== prev_data) begin
                    mismatch_count++;
                    $display("MISMATCH data held 0x%02h got 0x%02h", prev_data, data);
                end
            end
            if (data_valid && data_ready) begin
                if (exp_q.size() == 0) begin
                    other_count++;
                    $display("Data byte 0x%02h delivered when none was expected", data);
                end else begin
                    expected = exp_q.pop_front();
                    if (data !== expected) begin
                        mismatch_count++;
                        $display("MISMATCH data expected 0x%02h got 0x%02h", expected, data);
                    end
                end
            end
            prev_stall = data_valid && !data_ready;
            prev_data  = data;
        end
    end

    task automatic check_cmd(input logic [5:0] index, input logic [31:0] arg,
                             input logic check_arg);
        logic [37:0] entry;
        if (log_pos >= card_inst.cmd_log.size()) begin
            other_count++;
            $display("Command %0d was never sent to the card", index);
        end else begin
            entry = card_inst.cmd_log[log_pos];
            if (entry[37:32] !== index) begin
                mismatch_count++;
                $display("MISMATCH cmd_index expected 0x%02h got 0x%02h", index, entry[37:32]);
            end else if (check_arg && entry[31:0] !== arg) begin
                mismatch_count++;
                $display("MISMATCH cmd_arg expected 0x%08h got 0x%08h", arg, entry[31:0]);
            end
        end
        log_pos++;
    endtask

    task automatic send_request(input logic [31:0] sector, input logic [7:0] count);
        @(posedge clk);
        #1;
        req_valid  = 1'b1;
        req.sector = sector;
        req.count  = count;
        @(negedge clk);
        while (!req_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic run_read(input logic [31:0] sector, input logic [7:0] count);
        for (int b = 0; b < count; b++)
            for (int i = 0; i < `SD_BLOCK_BYTES; i++)
                exp_q.push_back(pattern_byte(sector + b, i));
        send_request(sector, count);
        while (exp_q.size() != 0)
            @(negedge clk);
        wait (!busy);
        @(negedge clk);
        for (int b = 0; b < count; b++)
            check_cmd(6'd17, sector + b, 1'b1);
        if (log_pos != card_inst.cmd_log.size()) begin
            other_count++;
            $display("Extra commands sent after a read of sector 0x%08h", sector);
        end
    endtask

    initial begin
        int     total_blocks;
        logic   busy_seen;
        int     n_cmds;
        longint fast_bytes;
        void'($urandom(93));
        clk            = 1'b0;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        data_ready     = 1'b0;
        fail_sector    = 32'hFFFF_FFFF;
        random_ready   = 1'b0;
        prev_stall     = 1'b0;
        prev_data      = '0;
        mismatch_count = 0;
        other_count    = 0;
        log_pos        = 0;
        total_blocks   = 1 + 2;  // Single-block read and the failing read
        for (int k = 0; k < NUM_RANDOM; k++) begin
            rnd_sector[k] = $urandom & 32'h0FFF_FFFF;
            rnd_count[k]  = 8'($urandom % 3 + 1);
            total_blocks += rnd_count[k];
        end
        fast_bytes  = longint'(total_blocks) * 530 + `SD_TOKEN_POLL_MAX + 64;
        watchdog_ns = 2 * (fast_bytes * (16 * `SD_DIV_READ + 8) * 100 +
                           100 * (16 * `SD_DIV_INIT + 8) * 100);

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (busy !== 1'b1 || error !== 1'b0 || data_valid !== 1'b0 || cs_n !== 1'b1 ||
            sck !== 1'b0 || mosi !== 1'b1 || req_ready !== 1'b1) begin
            other_count++;
            $display("Outputs after reset are not at their reset values");
        end

        // Start-up sequence
        wait (!busy);
        @(negedge clk);
        check_cmd(6'd0, 32'd0, 1'b0);
        check_cmd(6'd8, 32'd0, 1'b0);
        repeat (4) begin
            check_cmd(6'd55, 32'd0, 1'b0);
            check_cmd(6'd41, 32'd0, 1'b0);
        end
        check_cmd(6'd16, 32'd0, 1'b0);
        random_ready = 1'b1;

        run_read(32'h0000_1234, 8'd1);
        for (int k = 0; k < NUM_RANDOM; k++)
            run_read(rnd_sector[k], rnd_count[k]);

        // Zero-count request
        n_cmds    = card_inst.cmd_log.size();
        busy_seen = 1'b0;
        send_request(32'h0000_0042, 8'd0);
        repeat (20) begin
            @(negedge clk);
            if (busy)
                busy_seen = 1'b1;
        end
        if (busy_seen || card_inst.cmd_log.size() != n_cmds) begin
            other_count++;
            $display("Zero-count request started a read");
        end

        // Second block never gets its token
        fail_sector = rnd_sector[0] + 32'd1;
        for (int i = 0; i < `SD_BLOCK_BYTES; i++)
            exp_q.push_back(pattern_byte(rnd_sector[0], i));
        send_request(rnd_sector[0], 8'd2);
        wait (error);
        @(negedge clk);
        if (busy || !cs_n) begin
            other_count++;
            $display("After the error busy is not low or cs_n is not high");
        end
        if (exp_q.size() != 0) begin
            other_count++;
            $display("Block before the failing sector was not fully delivered");
        end
        check_cmd(6'd17, rnd_sector[0], 1'b1);
        check_cmd(6'd17, fail_sector, 1'b1);

        @(posedge clk);
        #1;
        req_valid  = 1'b1;
        req.sector = 32'h0000_0007;
        req.count  = 8'd1;
        repeat (3) @(negedge clk);
        if (req_ready) begin
            other_count++;
            $display("req_ready stayed high after an error with the request register full");
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #1;
        #(watchdog_ns);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* verif/sd_card_model.sv */
`timescale 1ns/1ps

module sd_card_model (
    input  logic        cs_n,
    input  logic        sck,
    input  logic        mosi,
    output logic        miso,
    input  logic [31:0] fail_sector
);
    import sd_proto_pkg::*;

    logic [37:0] cmd_log[$];   // {index, arg} of each command seen
    logic [7:0]  resp_q[$];
    logic [7:0]  frame[6];
    logic [7:0]  rx_sr;
    logic [7:0]  tx_sr;
    int          bit_cnt;
    int          frame_len;
    int          acmd41_seen;

    initial begin
        miso        = 1'b1;
        rx_sr       = 8'hFF;
        tx_sr       = 8'hFF;
        bit_cnt     = 0;
        frame_len   = 0;
        acmd41_seen = 0;
    end

    task automatic answer(input logic [5:0] index, input logic [31:0] arg);
        logic [7:0] base;
        base = arg[7:0] * 8'd7;
        cmd_log.push_back({index, arg});
        case (index)
            6'd0, 6'd55: resp_q.push_back(8'h01);
            6'd8: begin
                resp_q.push_back(8'h01);
                for (int i = 3; i >= 0; i--)
                    resp_q.push_back(arg[8*i +: 8]);  // R7 echo
            end
            6'd41: begin
                resp_q.push_back(acmd41_seen < 3 ? 8'h01 : 8'h00);
                acmd41_seen++;
            end
            6'd16: resp_q.push_back(8'h00);
            6'd17: begin
                resp_q.push_back(8'h00);
                if (arg != fail_sector) begin
                    resp_q.push_back(8'hFF);
                    resp_q.push_back(8'hFF);
                    resp_q.push_back(8'hFE);
                    for (int i = 0; i < 512; i++)
                        resp_q.push_back(base + i[7:0]);
                    resp_q.push_back(8'hA5);  // CRC, never checked
                    resp_q.push_back(8'h5A);
                end
            end
            default: resp_q.push_back(8'h04);  // Illegal command
        endcase
    endtask

    task automatic take_byte(input logic [7:0] b);
        if (frame_len != 0 || b[7:6] == 2'b01) begin
            frame[frame_len] = b;
            frame_len++;
            if (frame_len == 6) begin
                frame_len = 0;
                answer(frame[0][5:0], {frame[1], frame[2], frame[3], frame[4]});
            end
        end
    endtask

    always @(posedge sck) begin
        if (!cs_n) begin
            rx_sr = {rx_sr[6:0], mosi};
            bit_cnt++;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                take_byte(rx_sr);
            end
        end
    end

    // Mode 0: next bit goes out on the falling edge
    always @(negedge sck) begin
        if (!cs_n) begin
            if (bit_cnt == 0)
                tx_sr = (resp_q.size() != 0) ? resp_q.pop_front() : 8'hFF;
            else
                tx_sr = {tx_sr[6:0], 1'b1};
            miso = tx_sr[7];
        end
    end

    always @(posedge cs_n) begin
        miso    = 1'b1;
        bit_cnt = 0;
    end

endmodule

/* hw/sd_card_reader.sv */
`timescale 1ns/1ps

module sd_card_reader (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  sd_host_pkg::read_req_t  req,
    output logic                    data_valid,
    input  logic                    data_ready,
    output sd_host_pkg::data_byte_t data,
    output logic                    cs_n,
    output logic                    sck,
    output logic                    mosi,
    input  logic                    miso,
    output logic                    busy,
    output logic                    error
);
    import sd_host_pkg::*;
    import sd_proto_pkg::*;

    read_req_t  req_q;
    logic       req_q_valid;
    logic       req_q_ready;
    data_byte_t byte_d;
    logic       byte_valid;
    logic       byte_ready;
    sd_cmd_t    cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    logic       fill_valid;
    logic       fill_ready;
    logic       frame_sent;
    logic       tx_valid;
    logic       tx_ready;
    data_byte_t tx_byte;
    logic       rx_valid;
    data_byte_t rx_byte;
    logic       shifting;
    logic       fast_clk;
    logic       sck_rise;
    logic       sck_fall;

    sd_hold_reg #(.payload_t(read_req_t)) req_hold_inst (
        .clk(clk), .rst_n(rst_n),
        .in_valid(req_valid), .in_ready(req_ready), .in_data(req),
        .out_valid(req_q_valid), .out_ready(req_q_ready), .out_data(req_q)
    );

    sd_hold_reg #(.payload_t(data_byte_t)) data_hold_inst (
        .clk(clk), .rst_n(rst_n),
        .in_valid(byte_valid), .in_ready(byte_ready), .in_data(byte_d),
        .out_valid(data_valid), .out_ready(data_ready), .out_data(data)
    );

    sd_reader_ctrl ctrl_inst (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_q_valid), .req_ready(req_q_ready), .req(req_q),
        .data_valid(byte_valid), .data_ready(byte_ready), .data(byte_d),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
        .fill_valid(fill_valid), .fill_ready(fill_ready), .frame_sent(frame_sent),
        .rx_valid(rx_valid), .rx_byte(rx_byte),
        .fast_clk(fast_clk), .cs_n(cs_n), .busy(busy), .error(error)
    );

    sd_cmd_framer framer_inst (
        .clk(clk), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
        .fill_valid(fill_valid), .fill_ready(fill_ready), .frame_sent(frame_sent),
        .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_byte(tx_byte),
        .rx_valid(rx_valid)
    );

    spi_byte_shifter shifter_inst (
        .clk(clk), .rst_n(rst_n),
        .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_byte(tx_byte),
        .sck_rise(sck_rise), .sck_fall(sck_fall),
        .miso(miso), .mosi(mosi), .shifting(shifting),
        .rx_valid(rx_valid), .rx_byte(rx_byte)
    );

    spi_clock_gen clock_gen_inst (
        .clk(clk), .rst_n(rst_n),
        .shifting(shifting), .fast_clk(fast_clk),
        .sck(sck), .sck_rise(sck_rise), .sck_fall(sck_fall)
    );

endmodule

/* hw/sd_reader_ctrl.sv */
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_reader_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  sd_host_pkg::read_req_t  req,
    output logic                    data_valid,
    input  logic                    data_ready,
    output sd_host_pkg::data_byte_t data,
    output logic                    cmd_valid,
    input  logic                    cmd_ready,
    output sd_proto_pkg::sd_cmd_t   cmd,
    output logic                    fill_valid,
    input  logic                    fill_ready,
    input  logic                    frame_sent,
    input  logic                    rx_valid,
    input  sd_host_pkg::data_byte_t rx_byte,
    output logic                    fast_clk,
    output logic                    cs_n,
    output logic                    busy,
    output logic                    error
);
    import sd_proto_pkg::*;
    import sd_host_pkg::*;

    typedef enum logic [3:0] {
        S_POWER, S_SEND, S_FRAME, S_R1, S_DRAIN, S_IDLE, S_TOKEN, S_DATA, S_ERROR
    } state_t;

    state_t      state;
    sd_cmd_t     cmd_q;        // Its arg is also the current sector
    logic [7:0]  blocks_left;
    logic [9:0]  byte_cnt;
    logic [10:0] poll_cnt;
    logic [6:0]  retry_cnt;
    logic        fill_wait;    // Fill byte on the wire
    logic [7:0]  r1_expect;
    logic [9:0]  drain_last;

    assign cmd        = cmd_q;
    assign cmd_valid  = (state == S_SEND);
    assign req_ready  = (state == S_IDLE);
    assign cs_n       = (state inside {S_POWER, S_IDLE, S_ERROR});
    assign busy       = !(state inside {S_IDLE, S_ERROR});
    assign error      = (state == S_ERROR);
    assign data_valid = (state == S_DATA) && rx_valid;
    assign data       = rx_byte;
    // Next data byte only once the holding register has room
    assign fill_valid = !fill_wait && ((state inside {S_POWER, S_R1, S_TOKEN, S_DRAIN}) ||
                                       (state == S_DATA && data_ready));
    assign r1_expect  = (cmd_q.index inside {CMD0, CMD8, CMD55}) ? R1_IDLE : R1_READY;
    assign drain_last = (cmd_q.index == CMD8) ? 10'd3 : 10'd1;  // R7 tail or data CRC

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_POWER;
            cmd_q       <= '{index: CMD0, arg: 32'd0};
            blocks_left <= '0;
            byte_cnt    <= '0;
            poll_cnt    <= '0;
            retry_cnt   <= '0;
            fill_wait   <= 1'b0;
            fast_clk    <= 1'b0;
        end else begin
            if (fill_valid && fill_ready)
                fill_wait <= 1'b1;
            else if (rx_valid)
                fill_wait <= 1'b0;

            case (state)
                S_POWER: if (rx_valid) begin
                    if (byte_cnt == 10'(`SD_POWERUP_BYTES - 1)) begin
                        byte_cnt <= '0;
                        state    <= S_SEND;  // cmd_q holds CMD0 from reset
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                S_SEND: if (cmd_ready)
                    state <= S_FRAME;
                S_FRAME: if (frame_sent) begin
                    poll_cnt <= '0;
                    state    <= S_R1;
                end
                S_R1: if (rx_valid) begin
                    if (rx_byte[7]) begin  // Card still silent
                        if (poll_cnt == 11'(`SD_R1_POLL_MAX - 1))
                            state <= S_ERROR;
                        else
                            poll_cnt <= poll_cnt + 1'b1;
                    end else if (cmd_q.index == ACMD41 && rx_byte == R1_IDLE) begin
                        if (retry_cnt == 7'(`SD_ACMD41_RETRY_MAX - 1)) begin
                            state <= S_ERROR;
                        end else begin
                            retry_cnt <= retry_cnt + 1'b1;
                            cmd_q     <= '{index: CMD55, arg: 32'd0};
                            state     <= S_SEND;
                        end
                    end else if (rx_byte != r1_expect) begin
                        state <= S_ERROR;
                    end else begin
                        case (cmd_q.index)
                            CMD0: begin
                                cmd_q <= '{index: CMD8, arg: 32'h0000_01AA};  // 2.7-3.6 V
                                state <= S_SEND;
                            end
                            CMD8: begin
                                byte_cnt <= '0;
                                state    <= S_DRAIN;
                            end
                            CMD55: begin
                                cmd_q <= '{index: ACMD41, arg: 32'h4000_0000};  // HCS set
                                state <= S_SEND;
                            end
                            ACMD41: begin
                                cmd_q <= '{index: CMD16, arg: 32'(`SD_BLOCK_BYTES)};
                                state <= S_SEND;
                            end
                            CMD16: begin
                                fast_clk <= 1'b1;
                                state    <= S_IDLE;
                            end
                            default: begin  // CMD17
                                poll_cnt <= '0;
                                state    <= S_TOKEN;
                            end
                        endcase
                    end
                end
                S_IDLE: if (req_valid && req.count != 8'd0) begin
                    cmd_q       <= '{index: CMD17, arg: req.sector};
                    blocks_left <= req.count;
                    state       <= S_SEND;
                end
                S_TOKEN: if (rx_valid) begin
                    if (rx_byte == DATA_TOKEN) begin
                        byte_cnt <= '0;
                        state    <= S_DATA;
                    end else if (rx_byte != 8'hFF ||
                                 poll_cnt == 11'(`SD_TOKEN_POLL_MAX - 1)) begin
                        state <= S_ERROR;  // Error token or timeout
                    end else begin
                        poll_cnt <= poll_cnt + 1'b1;
                    end
                end
                S_DATA: if (rx_valid) begin
                    if (byte_cnt == 10'(`SD_BLOCK_BYTES - 1)) begin
                        byte_cnt <= '0;
                        state    <= S_DRAIN;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                S_DRAIN: if (rx_valid) begin
                    if (byte_cnt != drain_last) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end else if (cmd_q.index == CMD8) begin
                        byte_cnt <= '0;
                        cmd_q    <= '{index: CMD55, arg: 32'd0};
                        state    <= S_SEND;
                    end else begin
                        byte_cnt    <= '0;
                        blocks_left <= blocks_left - 1'b1;
                        cmd_q.arg   <= cmd_q.arg + 32'd1;
                        if (blocks_left == 8'd1)
                            state <= S_IDLE;
                        else
                            state <= S_SEND;
                    end
                end
                default: ;  // S_ERROR holds until reset
            endcase
        end
    end

    // Data byte requests wait for room, so the register never refuses one
    assert property (@(posedge clk) disable iff (!rst_n) data_valid |-> data_ready);

endmodule

/* hw/sd_hold_reg.sv */
`timescale 1ns/1ps

module sd_hold_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    logic     full;
    payload_t held;

    assign in_ready  = !full || out_ready;  // Refill in the drain cycle
    assign out_valid = full;
    assign out_data  = held;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            full <= 1'b0;
        else if (in_valid && in_ready)
            full <= 1'b1;
        else if (out_ready)
            full <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            held <= in_data;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* hw/sd_cmd_framer.sv */
`timescale 1ns/1ps

module sd_cmd_framer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  sd_proto_pkg::sd_cmd_t cmd,
    input  logic                  fill_valid,
    output logic                  fill_ready,
    output logic                  frame_sent,
    output logic                  tx_valid,
    input  logic                  tx_ready,
    output logic [7:0]            tx_byte,
    input  logic                  rx_valid
);
    import sd_proto_pkg::*;

    logic        active;
    logic [47:0] frame;
    logic [2:0]  tx_left;   // Bytes not yet handed to the shifter
    logic [2:0]  rx_left;   // Bytes not yet finished on the wire
    logic [7:0]  crc;

    // Only CMD0 and CMD8 are checked by the card in SPI mode
    always_comb begin
        case (cmd.index)
            CMD0:    crc = 8'h95;
            CMD8:    crc = 8'h87;
            default: crc = 8'hFF;
        endcase
    end

    assign cmd_ready  = !active && tx_ready;
    assign fill_ready = !active && tx_ready;
    assign tx_valid   = active ? (tx_left != 3'd0) : fill_valid;
    assign tx_byte    = active ? frame[47:40] : 8'hFF;
    assign frame_sent = active && rx_valid && (rx_left == 3'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            tx_left <= '0;
            rx_left <= '0;
        end else if (cmd_valid && cmd_ready) begin
            active  <= 1'b1;
            tx_left <= 3'd6;
            rx_left <= 3'd6;
        end else if (active) begin
            if (tx_valid && tx_ready)
                tx_left <= tx_left - 1'b1;
            if (rx_valid)
                rx_left <= rx_left - 1'b1;
            if (frame_sent)
                active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready)
            frame <= {2'b01, cmd.index, cmd.arg, crc};  // Start bits, index, arg, CRC
        else if (active && tx_valid && tx_ready)
            frame <= {frame[39:0], 8'hFF};
    end

endmodule

/* hw/spi_byte_shifter.sv */
`timescale 1ns/1ps

module spi_byte_shifter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tx_valid,
    output logic                    tx_ready,
    input  sd_host_pkg::data_byte_t tx_byte,
    input  logic                    sck_rise,
    input  logic                    sck_fall,
    input  logic                    miso,
    output logic                    mosi,
    output logic                    shifting,
    output logic                    rx_valid,
    output sd_host_pkg::data_byte_t rx_byte
);
    import sd_host_pkg::*;

    data_byte_t tx_sr;
    data_byte_t rx_sr;
    logic [2:0] bit_cnt;

    assign tx_ready = !shifting;
    assign rx_byte  = rx_sr;  // Untouched until the next byte's first rise

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shifting <= 1'b0;
            bit_cnt  <= '0;
            mosi     <= 1'b1;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (tx_valid && tx_ready) begin
                shifting <= 1'b1;
                bit_cnt  <= '0;
                mosi     <= tx_byte[7];  // MSB ready before first rise
            end else if (sck_fall) begin
                if (bit_cnt == 3'd7) begin
                    shifting <= 1'b0;
                    rx_valid <= 1'b1;
                    mosi     <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    mosi    <= tx_sr[6];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_valid && tx_ready)
            tx_sr <= tx_byte;
        else if (sck_fall)
            tx_sr <= {tx_sr[6:0], 1'b1};
        if (sck_rise)
            rx_sr <= {rx_sr[6:0], miso};  // MSB first
    end

    // Strobes only come while a byte is in progress
    assert property (@(posedge clk) disable iff (!rst_n)
        !shifting |-> !sck_rise && !sck_fall);

endmodule

/* hw/spi_clock_gen.sv */
`timescale 1ns/1ps
`include "sd_settings.svh"

module spi_clock_gen (
    input  logic clk,
    input  logic rst_n,
    input  logic shifting,
    input  logic fast_clk,
    output logic sck,
    output logic sck_rise,
    output logic sck_fall
);
    logic [7:0] div_cnt;
    logic [7:0] div_load;
    logic       tick;

    assign div_load = fast_clk ? 8'(`SD_DIV_READ - 1) : 8'(`SD_DIV_INIT - 1);
    assign tick     = shifting && (div_cnt == 8'd0);
    assign sck_rise = tick && !sck;  // Same cycle as the edge
    assign sck_fall = tick && sck;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end else if (!shifting) begin
            div_cnt <= div_load;  // First edge a full half-period after start
            sck     <= 1'b0;
        end else if (tick) begin
            div_cnt <= div_load;
            sck     <= !sck;
        end else begin
            div_cnt <= div_cnt - 1'b1;
        end
    end

    // Shifter stops only on a falling edge, so SCK is already low
    assert property (@(posedge clk) disable iff (!rst_n) !shifting |-> !sck);

endmodule

/* hw/sd_host_pkg.sv */
package sd_host_pkg;

    typedef logic [7:0] data_byte_t;

    typedef struct packed {
        logic [31:0] sector;  // First block address
        logic [7:0]  count;   // Zero means nothing to read
    } read_req_t;

endpackage

/* hw/sd_proto_pkg.sv */
package sd_proto_pkg;

    typedef enum logic [5:0] {
        CMD0   = 6'd0,   // GO_IDLE_STATE
        CMD8   = 6'd8,   // SEND_IF_COND
        CMD16  = 6'd16,  // SET_BLOCKLEN
        CMD17  = 6'd17,  // READ_SINGLE_BLOCK
        ACMD41 = 6'd41,  // SD_SEND_OP_COND
        CMD55  = 6'd55   // APP_CMD
    } cmd_index_t;

    typedef struct packed {
        cmd_index_t  index;
        logic [31:0] arg;
    } sd_cmd_t;

    localparam logic [7:0] R1_IDLE    = 8'h01;
    localparam logic [7:0] R1_READY   = 8'h00;
    localparam logic [7:0] DATA_TOKEN = 8'hFE;  // Start of single-block data

endpackage

/* hw/sd_settings.svh */
`ifndef SD_SETTINGS_SVH
`define SD_SETTINGS_SVH

// SCK half-period in clk cycles
`define SD_DIV_INIT 125
`define SD_DIV_READ 4

// 0xFF bytes sent with cs_n high before CMD0
`define SD_POWERUP_BYTES 10

`define SD_R1_POLL_MAX 8        // Bytes polled for an R1
`define SD_TOKEN_POLL_MAX 1024  // Bytes polled for the data token
`define SD_ACMD41_RETRY_MAX 100

`define SD_BLOCK_BYTES 512

`endif
